//--- hdl/tag_cfg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry of the two-way tag store
// Entry layout fixed by the 256x59 SRAM
// Group bits must match the SRAM split
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tag_cfg_pkg;

  // Set index, 256 sets per way
  localparam int INDEX_W = 8;

  // Field widths of one entry
  localparam int TAG_W   = 29;
  localparam int ATTR_W  = 29;
  localparam int ENTRY_W = 1 + TAG_W + ATTR_W;

  // Valid bit sits on top of the entry
  localparam int VALID_BIT    = ENTRY_W - 1;
  // WEN bits that steer the tag and attr groups
  localparam int TAG_GRP_BIT  = VALID_BIT - 1;
  localparam int ATTR_GRP_BIT = ATTR_W - 1;

  localparam int NUM_WAYS = 2;

endpackage

//--- hdl/tag_types_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command, entry and response types
// tag_entry_t bit order equals SRAM order
// Opcode value 3 is unused
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tag_types_pkg;
  import tag_cfg_pkg::*;

  // Tag store commands
  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_FILL   = 2'd1,
    OP_INVAL  = 2'd2
  } tag_op_e;

  // One stored entry, valid in bit 58
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [ATTR_W-1:0] attr;
  } tag_entry_t;

  // Incoming command, way only used by fill
  typedef struct packed {
    tag_op_e            op;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic [ATTR_W-1:0]  attr;
    logic               way;
  } tag_cmd_t;

  // Lookup result
  typedef struct packed {
    logic              hit;
    logic              hit_way;
    logic              multi_hit;
    logic [ATTR_W-1:0] attr;
  } tag_rsp_t;

  // SRAM control bundle for one way, all strobes active low
  typedef struct packed {
    logic               cen;
    logic               gwen;
    logic [ENTRY_W-1:0] wen;
    logic [ENTRY_W-1:0] d;
  } way_ctl_t;

endpackage

//--- hdl/fpga_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral single-port RAM
// Read-first, registered output
// Contents undefined until written
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fpga_ram #(
  parameter int WIDTH      = 32,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  CLK,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [WIDTH-1:0]      din,
  input  logic                  wen,
  output logic [WIDTH-1:0]      dout
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [WIDTH-1:0] mem [DEPTH];

  // Old data goes out while the new word lands
  always_ff @(posedge CLK) begin
    if (wen) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end

endmodule

//--- hdl/tag_sram_256x59.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One tag way, 256 x 59, single port
// CEN, GWEN and WEN are active low
// Writes act per group, not per bit
// Q holds while CEN stays high
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tag_sram_256x59
  import tag_cfg_pkg::*;
(
  input  logic               CLK,
  input  logic [INDEX_W-1:0] A,
  input  logic               CEN,
  input  logic [ENTRY_W-1:0] D,
  input  logic               GWEN,
  input  logic [ENTRY_W-1:0] WEN,
  output logic [ENTRY_W-1:0] Q
);

  logic [INDEX_W-1:0] addr_hold;
  logic [INDEX_W-1:0] addr;

  logic              valid_we;
  logic              tag_we;
  logic              attr_we;
  logic              valid_dout;
  logic [TAG_W-1:0]  tag_dout;
  logic [ATTR_W-1:0] attr_dout;

  // Group write enables, one WEN bit per group
  assign valid_we = !CEN && !GWEN && !WEN[VALID_BIT];
  assign tag_we   = !CEN && !GWEN && !WEN[TAG_GRP_BIT];
  assign attr_we  = !CEN && !GWEN && !WEN[ATTR_GRP_BIT];

  // Last enabled address
  always_ff @(posedge CLK) begin
    if (!CEN) begin
      addr_hold <= A;
    end
  end

  // Disabled cycles re-read the held address so Q does not move
  assign addr = CEN ? addr_hold : A;

  fpga_ram #(
    .WIDTH      (1),
    .ADDR_WIDTH (INDEX_W)
  ) ram_valid (
    .CLK  (CLK),
    .addr (addr),
    .din  (D[VALID_BIT]),
    .wen  (valid_we),
    .dout (valid_dout)
  );

  fpga_ram #(
    .WIDTH      (TAG_W),
    .ADDR_WIDTH (INDEX_W)
  ) ram_tag (
    .CLK  (CLK),
    .addr (addr),
    .din  (D[TAG_GRP_BIT -: TAG_W]),
    .wen  (tag_we),
    .dout (tag_dout)
  );

  fpga_ram #(
    .WIDTH      (ATTR_W),
    .ADDR_WIDTH (INDEX_W)
  ) ram_attr (
    .CLK  (CLK),
    .addr (addr),
    .din  (D[ATTR_GRP_BIT -: ATTR_W]),
    .wen  (attr_we),
    .dout (attr_dout)
  );

  // Reassemble the entry in SRAM bit order
  assign Q = {valid_dout, tag_dout, attr_dout};

endmodule

//--- hdl/tag_array_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command decode for both tag ways
// One command per cycle, no back-pressure
// cmd_valid is dropped while rst_n is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tag_array_ctrl
  import tag_cfg_pkg::*;
  import tag_types_pkg::*;
(
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               cmd_valid,
  input  tag_cmd_t           cmd,
  output way_ctl_t           ctl0,
  output way_ctl_t           ctl1,
  output logic [INDEX_W-1:0] index,
  output logic               lookup_pend,
  output logic [TAG_W-1:0]   pend_tag
);

  // Invalidate touches the valid group only
  localparam logic [ENTRY_W-1:0] INVAL_WEN = ~(ENTRY_W'(1) << VALID_BIT);

  logic       cmd_go;
  tag_entry_t wr_entry;
  way_ctl_t   ctl [NUM_WAYS];

  assign cmd_go = cmd_valid && rst_n;

  // Fill sets valid, invalidate clears it
  assign wr_entry.valid = (cmd.op == OP_FILL);
  assign wr_entry.tag   = cmd.tag;
  assign wr_entry.attr  = cmd.attr;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      // Idle, chip disabled and nothing written
      ctl[w].cen  = 1'b1;
      ctl[w].gwen = 1'b1;
      ctl[w].wen  = '1;
      ctl[w].d    = wr_entry;
      if (cmd_go) begin
        case (cmd.op)
          OP_LOOKUP: begin
            // Read both ways in parallel
            ctl[w].cen = 1'b0;
          end
          OP_FILL: begin
            // Whole entry, named way only
            if (cmd.way == w[0]) begin
              ctl[w].cen  = 1'b0;
              ctl[w].gwen = 1'b0;
              ctl[w].wen  = '0;
            end
          end
          OP_INVAL: begin
            ctl[w].cen  = 1'b0;
            ctl[w].gwen = 1'b0;
            ctl[w].wen  = INVAL_WEN;
          end
          default: begin
            // Unused opcode, stay idle
            ctl[w].cen = 1'b1;
          end
        endcase
      end
    end
  end

  assign ctl0  = ctl[0];
  assign ctl1  = ctl[1];
  assign index = cmd.index;

  // Lookup in decode this cycle, compared next cycle
  assign lookup_pend = cmd_go && (cmd.op == OP_LOOKUP);

  // Tag for the compare stage, lines up with the RAM read
  always_ff @(posedge CLK) begin
    if (lookup_pend) begin
      pend_tag <= cmd.tag;
    end
  end

endmodule

//--- hdl/tag_hit_merge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hit compare over both ways
// rsp fields valid only with rsp_valid
// Way 0 wins on a multi-hit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tag_hit_merge
  import tag_cfg_pkg::*;
  import tag_types_pkg::*;
(
  input  logic             CLK,
  input  logic             rst_n,
  input  logic             lookup_pend,
  input  logic [TAG_W-1:0] pend_tag,
  input  tag_entry_t       q0,
  input  tag_entry_t       q1,
  output logic             rsp_valid,
  output tag_rsp_t         rsp
);

  logic match0;
  logic match1;

  // Response strobe, one cycle after the lookup decode
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= lookup_pend;
    end
  end

  // Invalid entries never match, whatever their tag holds
  assign match0 = q0.valid && (q0.tag == pend_tag);
  assign match1 = q1.valid && (q1.tag == pend_tag);

  assign rsp.hit       = match0 || match1;
  assign rsp.hit_way   = match1 && !match0;
  // Same tag in both ways, software error
  assign rsp.multi_hit = match0 && match1;

  always_comb begin
    if (match0) begin
      rsp.attr = q0.attr;
    end else if (match1) begin
      rsp.attr = q1.attr;
    end else begin
      rsp.attr = '0;
    end
  end

endmodule

//--- hdl/tag_array_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-way tag store, top level
// Lookup result one cycle after command
// RAM is not cleared by reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tag_array_top
  import tag_cfg_pkg::*;
  import tag_types_pkg::*;
(
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     cmd_valid,
  input  tag_cmd_t cmd,
  output logic     rsp_valid,
  output tag_rsp_t rsp
);

  way_ctl_t           ctl0;
  way_ctl_t           ctl1;
  logic [INDEX_W-1:0] index;
  logic               lookup_pend;
  logic [TAG_W-1:0]   pend_tag;
  tag_entry_t         q0;
  tag_entry_t         q1;

  tag_array_ctrl i_ctrl (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .ctl0        (ctl0),
    .ctl1        (ctl1),
    .index       (index),
    .lookup_pend (lookup_pend),
    .pend_tag    (pend_tag)
  );

  // Both ways share the index
  tag_sram_256x59 i_way0 (
    .CLK  (CLK),
    .A    (index),
    .CEN  (ctl0.cen),
    .D    (ctl0.d),
    .GWEN (ctl0.gwen),
    .WEN  (ctl0.wen),
    .Q    (q0)
  );

  tag_sram_256x59 i_way1 (
    .CLK  (CLK),
    .A    (index),
    .CEN  (ctl1.cen),
    .D    (ctl1.d),
    .GWEN (ctl1.gwen),
    .WEN  (ctl1.wen),
    .Q    (q1)
  );

  tag_hit_merge i_merge (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .lookup_pend (lookup_pend),
    .pend_tag    (pend_tag),
    .q0          (q0),
    .q1          (q1),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

endmodule

//--- tb/tag_array_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing rules of the tag store top level
// Bound into every tag_array_top
// Idle while rst_n is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tag_array_asserts
  import tag_types_pkg::*;
(
  input logic     CLK,
  input logic     rst_n,
  input logic     cmd_valid,
  input tag_cmd_t cmd,
  input logic     rsp_valid,
  input tag_rsp_t rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions so far
  int fail_count = 0;

  logic lookup_in;

  assign lookup_in = cmd_valid && (cmd.op == OP_LOOKUP);

  // Response strobe one cycle after each lookup and in no other cycle
  a_rsp_timing: assert property (@(posedge CLK) disable iff (!rst_n)
    1'b1 |=> (rsp_valid == $past(lookup_in)))
    else begin
      $error("rsp_valid does not follow the lookup commands by one cycle");
      fail_count++;
    end

  // Both ways matching is still a hit
  a_multi_is_hit: assert property (@(posedge CLK) disable iff (!rst_n)
    (rsp_valid && rsp.multi_hit) |-> rsp.hit)
    else begin
      $error("multi_hit set without hit");
      fail_count++;
    end

  a_rsp_known: assert property (@(posedge CLK) disable iff (!rst_n)
    rsp_valid |-> !$isunknown(rsp))
    else begin
      $error("rsp has unknown bits while rsp_valid is high");
      fail_count++;
    end

endmodule

bind tag_array_top tag_array_asserts i_asserts (
  .CLK       (CLK),
  .rst_n     (rst_n),
  .cmd_valid (cmd_valid),
  .cmd       (cmd),
  .rsp_valid (rsp_valid),
  .rsp       (rsp)
);

//--- tb/tag_array_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the two-way tag store
// Sweeps every index with invalidates first
// RAM starts unknown, the model too
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tag_array_tb
  import tag_cfg_pkg::*;
  import tag_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TABLE_LEN = 19;
  localparam int RAND_CMDS = 64;
  localparam int WATCHDOG_CYCLES = (1 << INDEX_W) + TABLE_LEN + RAND_CMDS + 20;

  // One table row, exp only used by lookups
  typedef struct {
    int       test;
    tag_cmd_t cmd;
    tag_rsp_t exp;
  } row_t;

  logic        CLK = 1'b0;
  logic        rst_n;
  logic        cmd_valid;
  tag_cmd_t    cmd;
  logic        rsp_valid;
  tag_rsp_t    rsp;
  row_t        rows [TABLE_LEN];
  tag_entry_t  model_mem [NUM_WAYS][1 << INDEX_W];
  tag_rsp_t    exp_q [$];
  tag_rsp_t    exp_rsp;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] rnd = 32'h3afe;

  tag_array_top i_dut (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected lookup result from the model contents
  function automatic tag_rsp_t predict(input logic [INDEX_W-1:0] idx,
                                       input logic [TAG_W-1:0] tag);
    tag_rsp_t r;
    logic     hit0;
    logic     hit1;
    hit0 = (model_mem[0][idx].valid === 1'b1) && (model_mem[0][idx].tag === tag);
    hit1 = (model_mem[1][idx].valid === 1'b1) && (model_mem[1][idx].tag === tag);
    r.hit       = hit0 || hit1;
    r.hit_way   = hit1 && !hit0;
    r.multi_hit = hit0 && hit1;
    r.attr      = hit0 ? model_mem[0][idx].attr : (hit1 ? model_mem[1][idx].attr : '0);
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // Drive one command and mirror it in the model
  task automatic issue(input tag_cmd_t c, input tag_rsp_t exp);
    @(posedge CLK);
    cmd_valid <= 1'b1;
    cmd       <= c;
    case (c.op)
      OP_LOOKUP: exp_q.push_back(exp);
      OP_FILL:   model_mem[c.way][c.index] = '{1'b1, c.tag, c.attr};
      OP_INVAL: begin
        // Tag and attr stay as they were
        model_mem[0][c.index].valid = 1'b0;
        model_mem[1][c.index].valid = 1'b0;
      end
      default: ;
    endcase
  endtask

  // Go idle, then wait for all outstanding responses
  task automatic drain();
    @(posedge CLK);
    cmd_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge CLK);
      #1;
    end
  endtask

  // Responses compared mid-cycle, in issue order
  always @(negedge CLK) begin
    if (rst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("A response arrived with no lookup outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        check_value("rsp.hit", rsp.hit, exp_rsp.hit);
        check_value("rsp.hit_way", rsp.hit_way, exp_rsp.hit_way);
        check_value("rsp.multi_hit", rsp.multi_hit, exp_rsp.multi_hit);
        check_value("rsp.attr", rsp.attr, exp_rsp.attr);
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 40);
    $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

  initial begin
    tag_cmd_t c;
    int       err_before;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    // Swept array, every lookup misses
    rows[0]  = '{1, '{OP_LOOKUP, 8'h00, 29'h0000123, 29'h0, 1'b0}, {3'b000, 29'h0}};
    rows[1]  = '{1, '{OP_LOOKUP, 8'h7f, 29'h1fffffff, 29'h0, 1'b0}, {3'b000, 29'h0}};
    rows[2]  = '{1, '{OP_LOOKUP, 8'hff, 29'h0, 29'h0, 1'b0}, {3'b000, 29'h0}};
    // Single fill in way 0
    rows[3]  = '{2, '{OP_FILL, 8'h0a, 29'h0abcdef, 29'h1234567, 1'b0}, '0};
    rows[4]  = '{2, '{OP_LOOKUP, 8'h0a, 29'h0abcdef, 29'h0, 1'b0}, {3'b100, 29'h1234567}};
    rows[5]  = '{2, '{OP_LOOKUP, 8'h0a, 29'h0abcdee, 29'h0, 1'b0}, {3'b000, 29'h0}};
    // Two tags, one per way
    rows[6]  = '{3, '{OP_FILL, 8'h14, 29'h0111111, 29'h0aaaaaa, 1'b0}, '0};
    rows[7]  = '{3, '{OP_FILL, 8'h14, 29'h0222222, 29'h1555555, 1'b1}, '0};
    rows[8]  = '{3, '{OP_LOOKUP, 8'h14, 29'h0111111, 29'h0, 1'b0}, {3'b100, 29'h0aaaaaa}};
    rows[9]  = '{3, '{OP_LOOKUP, 8'h14, 29'h0222222, 29'h0, 1'b0}, {3'b110, 29'h1555555}};
    // Invalidate, then refill way 0 only
    rows[10] = '{4, '{OP_INVAL, 8'h14, 29'h0, 29'h0, 1'b0}, '0};
    rows[11] = '{4, '{OP_LOOKUP, 8'h14, 29'h0111111, 29'h0, 1'b0}, {3'b000, 29'h0}};
    rows[12] = '{4, '{OP_LOOKUP, 8'h14, 29'h0222222, 29'h0, 1'b0}, {3'b000, 29'h0}};
    rows[13] = '{4, '{OP_FILL, 8'h14, 29'h0111111, 29'h0033333, 1'b0}, '0};
    rows[14] = '{4, '{OP_LOOKUP, 8'h14, 29'h0111111, 29'h0, 1'b0}, {3'b100, 29'h0033333}};
    rows[15] = '{4, '{OP_LOOKUP, 8'h14, 29'h0222222, 29'h0, 1'b0}, {3'b000, 29'h0}};
    // Same tag in both ways
    rows[16] = '{5, '{OP_FILL, 8'h1e, 29'h1010101, 29'h0000abc, 1'b0}, '0};
    rows[17] = '{5, '{OP_FILL, 8'h1e, 29'h1010101, 29'h0000def, 1'b1}, '0};
    rows[18] = '{5, '{OP_LOOKUP, 8'h1e, 29'h1010101, 29'h0, 1'b0}, {3'b101, 29'h0000abc}};
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;
    for (int i = 0; i < (1 << INDEX_W); i++) begin
      c = '{OP_INVAL, i[INDEX_W-1:0], '0, '0, 1'b0};
      issue(c, '0);
    end
    for (int t = 1; t <= 5; t++) begin
      err_before = errors;
      for (int i = 0; i < TABLE_LEN; i++) begin
        if (rows[i].test == t) begin
          issue(rows[i].cmd, rows[i].exp);
        end
      end
      drain();
      $display("test %0d: %0d mismatches", t, errors - err_before);
    end
    // Small tag and index pools so hits and multi-hits occur
    err_before = errors;
    for (int i = 0; i < RAND_CMDS; i++) begin
      rnd     = xorshift(rnd);
      c.op    = rnd[0] ? OP_LOOKUP : OP_FILL;
      c.index = INDEX_W'(rnd[3:1]);
      c.tag   = TAG_W'(rnd[5:4]);
      c.attr  = rnd[31:3];
      c.way   = rnd[6];
      issue(c, predict(c.index, c.tag));
    end
    drain();
    $display("test 6: %0d mismatches", errors - err_before);
    errors += i_dut.i_asserts.fail_count;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/tag_cfg_pkg.sv
hdl/tag_types_pkg.sv
hdl/fpga_ram.sv
hdl/tag_sram_256x59.sv
hdl/tag_array_ctrl.sv
hdl/tag_hit_merge.sv
hdl/tag_array_top.sv
tb/tag_array_asserts.sv
tb/tag_array_tb.sv
